//--- heapArrays.f
design/heapPkg.sv
design/heapStageIf.sv
design/arrayDirectory.sv
design/elementStore.sv
design/heapArrays.sv
sim/heapArraysTb.sv

//--- Bender.yml
package:
  name: heapArrays

sources:
  - design/heapPkg.sv
  - design/heapStageIf.sv
  - design/arrayDirectory.sv
  - design/elementStore.sv
  - design/heapArrays.sv
  - target: test
    files:
      - sim/heapArraysTb.sv

//--- sim/heapArraysTb.sv
// Testbench for the array heap
// Directed tests, reference model, result checker and watchdog

`timescale 1ns/1ns

module heapArraysTb;

  localparam int addressBits  = 3;
  localparam int indexBits    = 3;
  localparam int dataBits     = 16;
  localparam int arrays       = 2 ** addressBits;
  localparam int arrayLength  = 2 ** indexBits;
  localparam int period       = 8;
  localparam int resetCycles  = 8;
  localparam int streamLength = 40;
  localparam int requestCount = 54 + streamLength;  // Directed plus random

  logic                   clock;
  logic                   reset;
  logic                   request;
  logic [3:0]             action;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    data;
  logic [dataBits-1:0]    result;
  logic                   resultValid;
  logic [3:0]             error;
  int                     cycles;                  // Rising edges so far

  logic                modelAllocated [arrays];    // Reference model state
  int                  modelHandedOut;
  int                  modelSize [arrays];
  logic [dataBits-1:0] modelMemory [arrays][arrayLength];
  int                  freeStack [$];              // Last freed at the back
  logic [dataBits-1:0] expectResult [$];           // Expected responses in order
  logic [3:0]          expectError [$];
  int                  expectCycle [$];

  heapArrays #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) dut (
    .clock(clock), .reset(reset), .request(request), .action(action), .array(array),
    .index(index), .data(data), .result(result), .resultValid(resultValid), .error(error)
  );

  always #(period / 2) clock = ~clock;
  always @(posedge clock) cycles <= cycles + 1;

  //----------------------------------------------------------------------
  // Failure reporting and compare
  //----------------------------------------------------------------------
  task automatic failWith(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      failWith($sformatf("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                         $time, name, actual, expected));
    end
  endtask

  // Responses checked in issue order at the falling edge
  always @(negedge clock) begin
    if (!reset && resultValid) begin
      if (expectCycle.size() == 0) begin
        failWith("resultValid pulsed with no request outstanding");
      end else begin
        checkValue("resultValid cycle", cycles, expectCycle.pop_front());
        checkValue("result", result, expectResult.pop_front());
        checkValue("error", error, expectError.pop_front());
      end
    end else if (!reset && expectCycle.size() != 0 && cycles >= expectCycle[0]) begin
      failWith($sformatf("No resultValid pulse for the request due at cycle %0d",
                         expectCycle[0]));
    end
  end

  //----------------------------------------------------------------------
  // Reference model and request driver
  //----------------------------------------------------------------------
  function automatic logic [3:0] accessCheck(input int arr);
    if (arr >= modelHandedOut) begin
      return heapPkg::errNotAllocated;
    end
    return modelAllocated[arr] ? heapPkg::errNone : heapPkg::errFreed;
  endfunction

  task automatic issue(input logic [3:0] act, input int arr, input int idx,
                       input logic [dataBits-1:0] value);
    logic [dataBits-1:0] res;
    logic [3:0]          err;
    int                  size;
    res  = '0;                                     // Zero on any error
    err  = accessCheck(arr);
    size = modelSize[arr];
    if (err == heapPkg::errNone) begin
      if ((act == heapPkg::opRead || act == heapPkg::opAdd) && idx >= size) begin
        err = heapPkg::errOutOfBounds;
      end else if (act == heapPkg::opPush && size == arrayLength) begin
        err = heapPkg::errFull;
      end else if (act == heapPkg::opPop && size == 0) begin
        err = heapPkg::errEmpty;
      end
    end
    if (act > heapPkg::opFree) begin
      err = heapPkg::errBadAction;                 // Unknown code, whatever the array
    end
    if (act == heapPkg::opAlloc) begin
      err = heapPkg::errNone;
      if (freeStack.size() != 0) begin
        res = freeStack.pop_back();                // Most recently freed first
      end else if (modelHandedOut < arrays) begin
        res = modelHandedOut;
        modelHandedOut++;
      end else begin
        err = heapPkg::errOutOfMemory;
      end
      if (err == heapPkg::errNone) begin
        modelAllocated[res] = 1'b1;
        modelSize[res]      = 0;
      end
    end else if (err == heapPkg::errNone) begin
      case (act)
        heapPkg::opWrite: begin
          modelMemory[arr][idx] = value;
          modelSize[arr]        = (idx >= size) ? idx + 1 : size;
          res                   = value;
        end
        heapPkg::opRead: res = modelMemory[arr][idx];
        heapPkg::opSize: res = size;
        heapPkg::opPush: begin
          modelMemory[arr][size] = value;
          modelSize[arr]         = size + 1;
          res                    = value;
        end
        heapPkg::opPop: begin
          modelSize[arr] = size - 1;
          res            = modelMemory[arr][size - 1];
        end
        heapPkg::opIndex: begin
          for (int i = 0; i < size; i++) begin
            if (modelMemory[arr][i] == value) res = i + 1;  // Last hit wins
          end
        end
        heapPkg::opAdd: begin
          modelMemory[arr][idx] = modelMemory[arr][idx] + value;  // Wraps
          res                   = modelMemory[arr][idx];
        end
        heapPkg::opFree: begin
          modelAllocated[arr] = 1'b0;
          freeStack.push_back(arr);
        end
        default: ;
      endcase
    end
    @(posedge clock);
    request <= 1'b1;
    action  <= act;
    array   <= arr;
    index   <= idx;
    data    <= value;
    expectResult.push_back(res);
    expectError.push_back(err);
    expectCycle.push_back(cycles + 3);             // Result three edges on
  endtask

  task automatic finishRequests();
    @(posedge clock);
    request <= 1'b0;
    while (expectCycle.size() != 0) @(posedge clock);
  endtask

  //----------------------------------------------------------------------
  // Directed tests
  //----------------------------------------------------------------------
  task automatic allocateAll();
    issue(heapPkg::opRead, 5, 0, '0);              // Nothing allocated yet
    issue(heapPkg::opWrite, 2, 1, $urandom);
    for (int i = 0; i <= arrays; i++) issue(heapPkg::opAlloc, 0, 0, '0);  // Ninth fails
    issue(4'd9, 0, 0, '0);                         // Unknown operation code
    finishRequests();
  endtask

  task automatic writeAndRead();
    for (int i = 0; i < 3; i++) issue(heapPkg::opWrite, 1, i, $urandom);
    issue(heapPkg::opSize, 1, 0, '0);
    for (int i = 0; i < 3; i++) issue(heapPkg::opRead, 1, i, '0);
    issue(heapPkg::opRead, 1, 5, '0);              // Beyond size three
    finishRequests();
  endtask

  task automatic pushAndPop();
    for (int i = 0; i <= arrayLength; i++) issue(heapPkg::opPush, 2, 0, $urandom);
    for (int i = 0; i <= arrayLength; i++) issue(heapPkg::opPop, 2, 0, '0);
    finishRequests();
  endtask

  task automatic indexAndAdd();
    logic [dataBits-1:0] first;
    first = $urandom;
    issue(heapPkg::opPush, 3, 0, first);
    issue(heapPkg::opPush, 3, 0, ~first);
    issue(heapPkg::opPush, 3, 0, first);
    issue(heapPkg::opPush, 3, 0, first ^ 16'h00ff);
    issue(heapPkg::opIndex, 3, 0, first);          // Hits at 0 and 2
    issue(heapPkg::opIndex, 3, 0, first ^ 16'h8000);  // Not stored
    issue(heapPkg::opAdd, 3, 1, $urandom);
    issue(heapPkg::opRead, 3, 1, '0);
    issue(heapPkg::opAdd, 3, 5, $urandom);         // Size is four
    finishRequests();
  endtask

  task automatic freeAndReuse();
    issue(heapPkg::opPush, 6, 0, $urandom);        // Size one before the free
    issue(heapPkg::opFree, 4, 0, '0);
    issue(heapPkg::opFree, 6, 0, '0);
    issue(heapPkg::opRead, 4, 0, '0);
    issue(heapPkg::opFree, 4, 0, '0);              // Double free
    issue(heapPkg::opAlloc, 0, 0, '0);             // Array 6 comes back
    issue(heapPkg::opSize, 6, 0, '0);
    finishRequests();
  endtask

  task automatic randomStream();
    int act;
    int arr;
    int idx;
    for (int n = 0; n < streamLength; n++) begin
      act = $urandom % 9;
      arr = $urandom % arrays;
      idx = $urandom % arrayLength;
      if (act == heapPkg::opWrite && idx > modelSize[arr]) idx = modelSize[arr];  // No gaps
      issue(act, arr, idx, $urandom);
    end
    finishRequests();
  endtask

  initial begin
    void'($urandom(27167));
    clock          = 1'b0;
    reset          = 1'b1;
    request        = 1'b0;
    action         = '0;
    array          = '0;
    index          = '0;
    data           = '0;
    cycles         = 0;
    modelHandedOut = 0;
    for (int i = 0; i < arrays; i++) begin
      modelAllocated[i] = 1'b0;
      modelSize[i]      = 0;
    end
    repeat (resetCycles) @(posedge clock);
    checkValue("resultValid", resultValid, 1'b0);  // Reset state of the outputs
    checkValue("error", error, heapPkg::errNone);
    reset <= 1'b0;
    allocateAll();
    writeAndRead();
    pushAndPop();
    indexAndAdd();
    freeAndReuse();
    randomStream();
    $display("Test OK");
    $finish;
  end

  // Watchdog
  initial begin
    #((requestCount * 8 + resetCycles) * period);
    failWith("Watchdog timeout with requests still outstanding");
  end

endmodule

//--- design/heapArrays.sv
// Top level of the array heap
// Two-stage pipeline, directory then element store

`timescale 1ns/1ns

module heapArrays #(
  parameter int addressBits = 3,               // Eight arrays by default
  parameter int indexBits   = 3,               // Eight elements per array
  parameter int dataBits    = 16
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   request,
  input  logic [3:0]             action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    data,
  output logic [dataBits-1:0]    result,
  output logic                   resultValid,
  output logic [3:0]             error
);

  heapStageIf #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    stageLink ();

  arrayDirectory #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    directory (
      .clock   (clock),
      .reset   (reset),
      .request (request),
      .action  (action),
      .array   (array),
      .index   (index),
      .data    (data),
      .stage   (stageLink.directory)
    );

  elementStore #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    store (
      .clock       (clock),
      .reset       (reset),
      .stage       (stageLink.store),
      .result      (result),
      .resultValid (resultValid),
      .error       (error)
    );

endmodule

//--- design/elementStore.sv
// Stage two of the array heap
// Element memory, element arithmetic, index search and result register

`timescale 1ns/1ns

module elementStore #(
  parameter int addressBits = 3,
  parameter int indexBits   = 3,
  parameter int dataBits    = 16
) (
  input  logic                clock,
  input  logic                reset,
  heapStageIf.store           stage,           // Checked request from stage one
  output logic [dataBits-1:0] result,
  output logic                resultValid,     // One cycle per request
  output logic [3:0]          error
);

  localparam int arrays      = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;

  typedef logic [dataBits-1:0] element;
  typedef logic [indexBits:0]  arraySize;

  element   memory [arrays][arrayLength];      // All arrays in fixed blocks
  element   storedValue;                       // Element at the slot
  element   sum;
  element   writeValue;
  element   nextResult;
  arraySize match;                             // Last match position plus one
  logic     writeEnable;

  //--------------------------------------------------------------------
  // Operation decode
  //--------------------------------------------------------------------
  always_comb begin
    storedValue = memory[stage.array][stage.slot];
    sum         = storedValue + stage.data;    // Wraps at dataBits
    match       = '0;
    for (int i = 0; i < arrayLength; i++) begin
      if (i < stage.size && memory[stage.array][i] == stage.data) begin
        match = arraySize'(i + 1);             // Later hits win
      end
    end

    writeEnable = 1'b0;
    writeValue  = stage.data;
    nextResult  = '0;                          // Failed requests return zero
    if (stage.error == heapPkg::errNone) begin
      case (stage.action)
        heapPkg::opWrite, heapPkg::opPush: begin
          writeEnable = stage.valid;
          nextResult  = stage.data;
        end
        heapPkg::opRead, heapPkg::opPop: nextResult = storedValue;
        heapPkg::opAdd: begin
          writeEnable = stage.valid;
          writeValue  = sum;
          nextResult  = sum;
        end
        heapPkg::opSize:  nextResult = element'(stage.size);
        heapPkg::opIndex: nextResult = element'(match);
        heapPkg::opAlloc: nextResult = element'(stage.array);  // Chosen array
        default: nextResult = '0;              // Free
      endcase
    end
  end

  //--------------------------------------------------------------------
  // Registers
  //--------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[stage.array][stage.slot] <= writeValue;
    end
    if (stage.valid) begin
      result <= nextResult;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      resultValid <= 1'b0;
      error       <= heapPkg::errNone;
    end else begin
      resultValid <= stage.valid;
      if (stage.valid) begin
        error <= stage.error;                  // Held until next request
      end
    end
  end

endmodule

//--- design/arrayDirectory.sv
// Stage one of the array heap
// Allocation flags, free stack, size table and request checks

`timescale 1ns/1ns

module arrayDirectory #(
  parameter int addressBits = 3,
  parameter int indexBits   = 3,
  parameter int dataBits    = 16
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   request,      // Strobe, one per request
  input  logic [3:0]             action,       // Raw operation code
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    data,
  heapStageIf.directory          stage         // Checked request to stage two
);

  localparam int arrays      = 2 ** addressBits;  // Arrays in the pool
  localparam int arrayLength = 2 ** indexBits;    // Elements per array

  typedef logic [addressBits-1:0] arrayId;
  typedef logic [addressBits:0]   arrayCount;     // Counts up to arrays inclusive
  typedef logic [indexBits:0]     arraySize;

  //--------------------------------------------------------------------
  // State
  //--------------------------------------------------------------------
  logic      allocated [arrays];               // Array currently handed out
  arraySize  sizes     [arrays];               // Current size per array
  arrayId    freeStack [arrays];               // Freed arrays, last in first out
  arrayCount freeTop;                          // Entries on the free stack
  arrayCount handedOut;                        // Fresh arrays given so far

  heapPkg::heapAction actionCode;
  heapPkg::heapError  accessError;             // Allocation check alone
  heapPkg::heapError  nextError;
  arraySize           currentSize;
  arraySize           nextSize;
  logic [indexBits-1:0] nextSlot;
  arrayId             nextArray;
  arrayId             stackTop;                // Entry to reuse on alloc
  logic               reuse;                   // Free stack not empty

  assign actionCode  = heapPkg::heapAction'(action);
  assign currentSize = sizes[array];
  assign reuse       = (freeTop != '0);
  assign stackTop    = arrayId'(freeTop - 1'b1);

  always_comb begin
    if ({1'b0, array} >= handedOut) begin
      accessError = heapPkg::errNotAllocated;
    end else if (!allocated[array]) begin
      accessError = heapPkg::errFreed;
    end else begin
      accessError = heapPkg::errNone;
    end
  end

  //--------------------------------------------------------------------
  // Checks and new size per operation
  //--------------------------------------------------------------------
  always_comb begin
    nextError = accessError;                   // Most operations need a live array
    nextSize  = currentSize;
    nextSlot  = index;                         // Write, Read, Add act at index
    nextArray = array;
    case (actionCode)
      heapPkg::opWrite: begin
        if (arraySize'(index) >= currentSize) begin
          nextSize = arraySize'(index) + arraySize'(1);  // Grow only
        end
      end
      heapPkg::opRead, heapPkg::opAdd: begin
        if (accessError == heapPkg::errNone && arraySize'(index) >= currentSize) begin
          nextError = heapPkg::errOutOfBounds;
        end
      end
      heapPkg::opSize, heapPkg::opIndex, heapPkg::opFree: begin
      end
      heapPkg::opPush: begin
        nextSlot = currentSize[indexBits-1:0];           // Old size
        nextSize = currentSize + arraySize'(1);
        if (accessError == heapPkg::errNone && currentSize == arraySize'(arrayLength)) begin
          nextError = heapPkg::errFull;
        end
      end
      heapPkg::opPop: begin
        nextSize = currentSize - arraySize'(1);
        nextSlot = nextSize[indexBits-1:0];              // New size
        if (accessError == heapPkg::errNone && currentSize == '0) begin
          nextError = heapPkg::errEmpty;
        end
      end
      heapPkg::opAlloc: begin
        nextSize  = '0;                                  // Fresh array is empty
        nextError = heapPkg::errNone;
        if (reuse) begin
          nextArray = freeStack[stackTop];
        end else if (handedOut < arrays) begin
          nextArray = arrayId'(handedOut);
        end else begin
          nextError = heapPkg::errOutOfMemory;
        end
      end
      default: nextError = heapPkg::errBadAction;
    endcase
  end

  //--------------------------------------------------------------------
  // Control state
  //--------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocated   <= '{default: 1'b0};
      freeTop     <= '0;
      handedOut   <= '0;
      stage.valid <= 1'b0;
    end else begin
      stage.valid <= request;
      if (request && nextError == heapPkg::errNone) begin
        if (actionCode == heapPkg::opAlloc) begin
          allocated[nextArray] <= 1'b1;
          if (reuse) begin
            freeTop <= freeTop - 1'b1;         // Pop free stack
          end else begin
            handedOut <= handedOut + 1'b1;
          end
        end else if (actionCode == heapPkg::opFree) begin
          allocated[array] <= 1'b0;
          freeTop          <= freeTop + 1'b1;
        end
      end
    end
  end

  // Sizes, free stack entries and the stage payload
  always_ff @(posedge clock) begin
    if (request && nextError == heapPkg::errNone) begin
      case (actionCode)
        heapPkg::opWrite, heapPkg::opPush, heapPkg::opPop: sizes[array] <= nextSize;
        heapPkg::opAlloc: sizes[nextArray] <= '0;
        heapPkg::opFree:  freeStack[freeTop[addressBits-1:0]] <= array;
        default: ;
      endcase
    end
    stage.action <= actionCode;
    stage.array  <= nextArray;
    stage.index  <= index;
    stage.data   <= data;
    stage.size   <= nextSize;
    stage.slot   <= nextSlot;
    stage.error  <= nextError;
  end

endmodule

//--- design/heapStageIf.sv
// Pipeline link between the array directory and the element store
// Carries one checked request per valid pulse

`timescale 1ns/1ns

interface heapStageIf #(
  parameter int addressBits = 3,               // Bits in an array number
  parameter int indexBits   = 3,               // Bits in an element index
  parameter int dataBits    = 16               // Bits in an element
);

  typedef logic [indexBits:0] arraySize;       // Size can reach the full length

  logic                     valid;             // One pulse per request
  heapPkg::heapAction       action;            // Operation to perform
  logic [addressBits-1:0]   array;             // Target array, or chosen one on alloc
  logic [indexBits-1:0]     index;             // Index as requested
  logic [dataBits-1:0]      data;              // Operand
  arraySize                 size;              // Size after stage one update
  logic [indexBits-1:0]     slot;              // Element position to act on
  heapPkg::heapError        error;             // Check outcome

  modport directory (output valid, action, array, index, data, size, slot, error);
  modport store     (input  valid, action, array, index, data, size, slot, error);

endinterface

//--- design/heapPkg.sv
// Shared enums for the array heap
// Operation codes and error codes used by both pipeline stages

package heapPkg;

  //--------------------------------------------------------------------
  // Requested operation
  //--------------------------------------------------------------------
  typedef enum logic [3:0] {
    opWrite = 4'd0,                            // Write an element, grow size
    opRead  = 4'd1,                            // Read an element
    opSize  = 4'd2,                            // Current size of array
    opPush  = 4'd3,                            // Append an element
    opPop   = 4'd4,                            // Remove last element
    opIndex = 4'd5,                            // Last match position plus one
    opAdd   = 4'd6,                            // Add to element, return new value
    opAlloc = 4'd7,                            // Hand out an array
    opFree  = 4'd8                             // Return an array to the pool
  } heapAction;

  //--------------------------------------------------------------------
  // Result status
  //--------------------------------------------------------------------
  typedef enum logic [3:0] {
    errNone         = 4'd0,                    // Request completed
    errNotAllocated = 4'd1,                    // Array never handed out
    errFreed        = 4'd2,                    // Array freed, or freed twice
    errOutOfBounds  = 4'd3,                    // Index at or beyond size
    errFull         = 4'd4,                    // Push to full array
    errEmpty        = 4'd5,                    // Pop from empty array
    errOutOfMemory  = 4'd6,                    // No array left to allocate
    errBadAction    = 4'd7                     // Unknown operation code
  } heapError;

endpackage
